//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module firEngineTb -f firEngine.f -o simFir
	@out="$$(./obj_dir/simFir)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only --timing -Wall --top-module firEngineTb -f firEngine.f

clean:
	rm -rf obj_dir

//--- bench/firChecker.sv
`timescale 1ns/10ps

module firChecker (
    input  logic           iClk,
    input  logic           iRst,
    input  logic           iData0Changed,
    input  firPkg::sampleT iData0,
    input  logic           iData1Changed,
    input  firPkg::sampleT iData1,
    input  logic           iCoefWrEn,
    input  logic [3:0]     iCoefWrAddr,
    input  firPkg::sampleT iCoefWrData,
    input  logic           oData0Changed,
    input  firPkg::sampleT oData0,
    input  logic           oData1Changed,
    input  firPkg::sampleT oData1,
    input  logic           endCheck,
    output int             mismatchCount,
    output int             otherCount
);

    localparam int NumTaps [2] = '{6, 5};   // lenM1 plus one
    localparam int Origin [2] = '{0, 8};    // Offset with the region mask cleared

    firPkg::sampleT coef [16];
    firPkg::sampleT hist [2][6];    // Index 0 is the newest sample
    firPkg::sampleT expQ0 [$];
    firPkg::sampleT expQ1 [$];
    logic [1:0]     inTogQ;
    logic [1:0]     outTogQ;
    int             inCnt [2];
    int             outCnt [2];
    logic [1:0]     idleReported;
    logic           endDone;
    logic           inTog;
    logic           outTog;
    firPkg::sampleT outVal;
    firPkg::sampleT expVal;

    initial begin
        for (int a = 0; a < 16; a++)
            coef[a] = firPkg::InitCoef[a];
        for (int c = 0; c < 2; c++) begin
            for (int k = 0; k < 6; k++)
                hist[c][k] = '0;
            inCnt[c] = 0;
            outCnt[c] = 0;
        end
        inTogQ = '0;
        outTogQ = '0;
        idleReported = '0;
        endDone = 1'b0;
        mismatchCount = 0;
        otherCount = 0;
    end

    //////////////////////////////////////////////////
    // Reference FIR model
    //////////////////////////////////////////////////
    task automatic pushSample(input int c, input firPkg::sampleT value);
        for (int k = 5; k > 0; k--)
            hist[c][k] = hist[c][k - 1];
        hist[c][0] = value;
    endtask

    // Full-precision sum, then the published bit window
    function automatic firPkg::sampleT firOutput(input int c);
        longint sum;
        sum = 0;
        for (int k = 0; k < NumTaps[c]; k++)
            sum = sum + longint'(coef[Origin[c] + k]) * longint'(hist[c][k]);
        return sum[33:16];
    endfunction

    //////////////////////////////////////////////////
    // Port watcher
    //////////////////////////////////////////////////
    always @(posedge iClk) begin
        if (!iRst) begin
            if (iCoefWrEn)
                coef[iCoefWrAddr] = iCoefWrData;
            for (int c = 0; c < 2; c++) begin
                inTog = (c == 0) ? iData0Changed : iData1Changed;
                outTog = (c == 0) ? oData0Changed : oData1Changed;
                outVal = (c == 0) ? oData0 : oData1;
                // New input sample
                if (inTog != inTogQ[c]) begin
                    inTogQ[c] = inTog;
                    pushSample(c, (c == 0) ? iData0 : iData1);
                    expVal = firOutput(c);
                    if (c == 0)
                        expQ0.push_back(expVal);
                    else
                        expQ1.push_back(expVal);
                    inCnt[c]++;
                end
                // Output toggle, data settled a cycle earlier
                if (outTog != outTogQ[c]) begin
                    outTogQ[c] = outTog;
                    outCnt[c]++;
                    if ((c == 0 && expQ0.size() == 0) || (c == 1 && expQ1.size() == 0)) begin
                        $display("output toggle on channel %0d with no sample outstanding", c);
                        otherCount++;
                    end else begin
                        expVal = (c == 0) ? expQ0.pop_front() : expQ1.pop_front();
                        if (outVal != expVal) begin
                            $display("mismatch oData%0d: got 0x%h, expected 0x%h",
                                c, outVal, expVal);
                            mismatchCount++;
                        end
                    end
                end else if (inCnt[c] == 0 && outVal != '0 && !idleReported[c]) begin
                    $display("mismatch oData%0d before first sample: got 0x%h, expected 0x00000",
                        c, outVal);
                    idleReported[c] = 1'b1;   // Once per channel
                    mismatchCount++;
                end
            end
            // Toggle count per channel
            if (endCheck && !endDone) begin
                endDone = 1'b1;
                for (int c = 0; c < 2; c++) begin
                    if (outCnt[c] != inCnt[c]) begin
                        $display("channel %0d got %0d samples but gave %0d output toggles",
                            c, inCnt[c], outCnt[c]);
                        otherCount++;
                    end
                end
            end
        end
    end

endmodule

//--- bench/firEngineTb.sv
`timescale 1ns/10ps

// Clock and power-on reset for the testbench
module firClock #(
    parameter int ResetCycles = 4
) (
    output logic iClk,
    output logic iRst
);

    initial begin
        iClk = 1'b0;
        forever #10 iClk = ~iClk;   // 20 ns period
    end

    initial begin
        iRst = 1'b1;
        repeat (ResetCycles) @(posedge iClk);
        iRst <= 1'b0;
    end

endmodule

module firEngineTb;

    localparam int StreamLen = 24;                             // Random samples per channel
    localparam int RoundLen = 8;                               // Samples per channel after a coef write
    localparam int NumSamples = 1 + 2 * StreamLen + 4 * RoundLen;
    localparam int TimeoutCycles = NumSamples * 3 * 32 + 200;

    logic           iClk;
    logic           iRst;
    logic           iData0Changed;
    firPkg::sampleT iData0;
    logic           iData1Changed;
    firPkg::sampleT iData1;
    logic           iCoefWrEn;
    logic [3:0]     iCoefWrAddr;
    firPkg::sampleT iCoefWrData;
    logic           oData0Changed;
    firPkg::sampleT oData0;
    logic           oData1Changed;
    firPkg::sampleT oData1;
    logic           endCheck;
    int             mismatchCount;
    int             otherCount;
    int             cycleCnt = 0;
    logic [31:0]    rng;
    firPkg::sampleT samp [2][StreamLen + 2 * RoundLen];
    int             gapLen [2][StreamLen + 2 * RoundLen];

    firClock uClk (.iClk, .iRst);

    firEngine #(.LogTimeSlices(5), .LogBufferDepth(4), .LogNumFifos(1)) DUT (
        .iClk, .iRst, .iData0Changed, .iData0, .iData1Changed, .iData1,
        .iCoefWrEn, .iCoefWrAddr, .iCoefWrData,
        .oData0Changed, .oData0, .oData1Changed, .oData1
    );

    firChecker uChk (
        .iClk, .iRst, .iData0Changed, .iData0, .iData1Changed, .iData1,
        .iCoefWrEn, .iCoefWrAddr, .iCoefWrData,
        .oData0Changed, .oData0, .oData1Changed, .oData1,
        .endCheck, .mismatchCount, .otherCount
    );

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // One sample, then wait for the channel's output toggle
    task automatic sendSample(input int chan, input firPkg::sampleT value, input int gap);
        logic oldTog;
        repeat (gap) @(posedge iClk);
        oldTog = (chan == 0) ? oData0Changed : oData1Changed;
        @(posedge iClk);
        if (chan == 0) begin
            iData0 <= value;
            iData0Changed <= ~iData0Changed;
        end else begin
            iData1 <= value;
            iData1Changed <= ~iData1Changed;
        end
        do @(posedge iClk);
        while (((chan == 0) ? oData0Changed : oData1Changed) == oldTog);   // Global timeout guards
    endtask

    task automatic runStream(input int chan, input int first, input int count);
        for (int i = first; i < first + count; i++)
            sendSample(chan, samp[chan][i], gapLen[chan][i]);
    endtask

    // Only called with both channels idle
    task automatic writeCoef(input logic [3:0] addr, input firPkg::sampleT value);
        @(posedge iClk);
        iCoefWrEn <= 1'b1;
        iCoefWrAddr <= addr;
        iCoefWrData <= value;
        @(posedge iClk);
        iCoefWrEn <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        iData0Changed = 1'b0;
        iData0 = '0;
        iData1Changed = 1'b0;
        iData1 = '0;
        iCoefWrEn = 1'b0;
        iCoefWrAddr = '0;
        iCoefWrData = '0;
        endCheck = 1'b0;
        rng = 32'hf215;
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < StreamLen + 2 * RoundLen; i++) begin
                rng = lcgNext(rng);
                samp[c][i] = rng[31:14];   // Full-scale 18-bit sample
                rng = lcgNext(rng);
                gapLen[c][i] = rng[27:24];
            end
        end
        wait (iRst == 1'b0);
        repeat (40) @(posedge iClk);   // Outputs must stay quiet here
        sendSample(0, 18'h0b3c5, 0);   // Single sample on channel 0
        fork
            runStream(0, 0, StreamLen);
            runStream(1, 0, StreamLen);
        join
        writeCoef(4'd10, 18'h1e00d);   // Channel 1 region
        fork
            runStream(0, StreamLen, RoundLen);
            runStream(1, StreamLen, RoundLen);
        join
        writeCoef(4'd3, 18'h3a5a5);    // Channel 0 region
        fork
            runStream(0, StreamLen + RoundLen, RoundLen);
            runStream(1, StreamLen + RoundLen, RoundLen);
        join
        @(posedge iClk);
        endCheck <= 1'b1;
        repeat (2) @(posedge iClk);
        $display("errors: %0d mismatch, %0d other", mismatchCount, otherCount);
        if (mismatchCount + otherCount == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Run limit
    always @(posedge iClk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt == TimeoutCycles) begin
            $display("timeout: test did not finish within %0d cycles", TimeoutCycles);
            $display("errors: %0d mismatch, %0d other, 1 timeout", mismatchCount, otherCount);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

//--- firEngine.f
src/firPkg.sv
src/sliceSequencer.sv
src/sampleCapture.sv
src/tapAddressGen.sv
src/macDatapath.sv
src/outputPublisher.sv
src/firEngine.sv
bench/firChecker.sv
bench/firEngineTb.sv

//--- src/firEngine.sv
`timescale 1ns/10ps

module firEngine #(
    parameter int LogTimeSlices  = 5,
    parameter int LogBufferDepth = 4,
    parameter int LogNumFifos    = 1
) (
    input  logic                      iClk,
    input  logic                      iRst,
    input  logic                      iData0Changed,   // Flips once per new sample
    input  firPkg::sampleT            iData0,
    input  logic                      iData1Changed,
    input  firPkg::sampleT            iData1,
    input  logic                      iCoefWrEn,
    input  logic [LogBufferDepth-1:0] iCoefWrAddr,
    input  firPkg::sampleT            iCoefWrData,
    output logic                      oData0Changed,   // Flips one cycle after oData0 settles
    output firPkg::sampleT            oData0,
    output logic                      oData1Changed,
    output firPkg::sampleT            oData1
);

    firPkg::slotEntryT slotPs1;
    firPkg::slotEntryT slotPs2;
    firPkg::sampleT    pendingData;
    logic              pendingNew;
    firPkg::tapCtlT    tapCtl;
    firPkg::resultT    result;

    // Schedule source, late copies left for probing
    sliceSequencer #(.LogTimeSlices(LogTimeSlices)) uSeq (
        .iClk, .iRst, .slotPs1, .slotPs2, .slotPs3(), .slotPs8()
    );

    sampleCapture uCap (
        .iClk, .iRst, .iData0Changed, .iData0, .iData1Changed, .iData1,
        .slotPs1, .pendingData, .pendingNew
    );

    tapAddressGen #(.LogBufferDepth(LogBufferDepth), .LogNumFifos(LogNumFifos)) uAddr (
        .iClk, .iRst, .slotPs2, .pendingNew, .tapCtl
    );

    macDatapath #(.LogBufferDepth(LogBufferDepth)) uMac (
        .iClk, .iCoefWrEn, .iCoefWrAddr, .iCoefWrData, .tapCtl, .pendingData, .result
    );

    outputPublisher uOut (
        .iClk, .iRst, .result, .oData0, .oData0Changed, .oData1, .oData1Changed
    );

endmodule

//--- src/firPkg.sv
package firPkg;

    typedef logic signed [17:0] sampleT;   // Sample and coefficient word
    typedef logic signed [47:0] accT;      // MAC accumulator

    typedef enum logic [1:0] {
        macIdle,                           // Accumulator holds
        macMul,                            // Start a new sum
        macMadd                            // Add product to the sum
    } macOpT;

    localparam logic [1:0] ChanNone = 2'd3;   // Slot serves no input channel
    localparam int ResultShift = 16;          // Lowest published accumulator bit

    typedef struct packed {
        logic [1:0] chanSel;   // Input channel pushed in this slot
        logic       doUpdate;  // Push the pending sample
        logic       firstTap;
        logic       lastTap;
        macOpT      macOp;
        logic       fifoNum;   // History buffer of this slot
    } slotEntryT;

    typedef slotEntryT [31:0] scheduleT;

    typedef struct packed {
        logic [9:0] offset;    // Newest entry
        logic [5:0] lenM1;     // Length minus one
    } fifoDescT;

    typedef struct packed {
        logic [3:0] histAddr;
        logic [3:0] coefAddr;
        logic [3:0] wrAddr;    // History push address
        logic       wrEn;
        macOpT      macOp;
        logic       lastTap;
        logic       commit;    // Sum is published at lastTap
        logic       chan;
        logic [5:0] spare;
    } tapCtlT;

    typedef struct packed {
        sampleT value;
        logic   chan;
        logic   strobe;
    } resultT;

    localparam fifoDescT InitFifoDesc [2] = '{
        '{offset: 10'd0, lenM1: 6'd5},     // Channel 0, six taps
        '{offset: 10'd8, lenM1: 6'd4}      // Channel 1, five taps
    };

    // Channel 0 region 0..7, channel 1 region 8..15
    localparam sampleT InitCoef [16] = '{
        18'h06666, 18'h19999, 18'h26667, 18'h0999a, 18'h03333, 18'h01111, 18'h00000, 18'h00000,
        18'h03333, 18'h06666, 18'h09999, 18'h10000, 18'h3c000, 18'h00000, 18'h00000, 18'h00000
    };

    // Update slot at the head of each 16-slot group, taps right behind it
    function automatic scheduleT buildSchedule();
        scheduleT s;
        int base;
        s = '0;
        for (int i = 0; i < 32; i++) begin
            s[i].chanSel = ChanNone;
            s[i].fifoNum = i[4];           // Upper half of frame is channel 1
        end
        for (int c = 0; c < 2; c++) begin
            base = 16 * c;
            s[base].chanSel = c[1:0];
            s[base].doUpdate = 1'b1;
            for (int k = 0; k <= InitFifoDesc[c].lenM1; k++) begin
                s[base + 1 + k].firstTap = (k == 0);
                s[base + 1 + k].lastTap = (k == InitFifoDesc[c].lenM1);
                s[base + 1 + k].macOp = (k == 0) ? macMul : macMadd;
            end
        end
        return s;
    endfunction

    localparam scheduleT FrameSchedule = buildSchedule();

endpackage

//--- src/macDatapath.sv
`timescale 1ns/10ps

module macDatapath #(
    parameter int LogBufferDepth = 4
) (
    input  logic                      iClk,
    input  logic                      iCoefWrEn,
    input  logic [LogBufferDepth-1:0] iCoefWrAddr,
    input  firPkg::sampleT            iCoefWrData,
    input  firPkg::tapCtlT            tapCtl,        // ps4
    input  firPkg::sampleT            pendingData,
    output firPkg::resultT            result         // ps9
);

    localparam int Depth = 1 << LogBufferDepth;

    firPkg::sampleT          coefMem [Depth];
    firPkg::sampleT          histMem [Depth];
    firPkg::sampleT          coefRd1;
    firPkg::sampleT          coefRd2;   // ps6
    firPkg::sampleT          histRd1;
    firPkg::sampleT          histRd2;   // ps6
    logic signed [35:0]      product;   // ps7
    firPkg::accT             acc;       // ps8
    firPkg::tapCtlT [3:0]    ctlPipe = '0;   // ps5 to ps8, clean from power-up

    initial begin
        for (int a = 0; a < Depth; a++) begin
            coefMem[a] = firPkg::InitCoef[a];
            histMem[a] = '0;
        end
    end

    //////////////////////////////////////////////////
    // RAMs, two-cycle read
    //////////////////////////////////////////////////
    always @(posedge iClk) begin
        if (iCoefWrEn)
            coefMem[iCoefWrAddr] <= iCoefWrData;
        coefRd1 <= coefMem[tapCtl.coefAddr];
        coefRd2 <= coefRd1;
    end

    always @(posedge iClk) begin
        if (tapCtl.wrEn)
            histMem[tapCtl.wrAddr] <= pendingData;   // Push at the new offset
        histRd1 <= histMem[tapCtl.histAddr];
        histRd2 <= histRd1;
    end

    //////////////////////////////////////////////////
    // Multiply-accumulate
    //////////////////////////////////////////////////
    always_ff @(posedge iClk) begin
        ctlPipe <= {ctlPipe[2:0], tapCtl};
        product <= coefRd2 * histRd2;        // Signed 18x18
        case (ctlPipe[2].macOp)
            firPkg::macMul:  acc <= product;   // Sign extended load
            firPkg::macMadd: acc <= acc + product;
            default:         acc <= acc;
        endcase
        result.value <= acc[firPkg::ResultShift +: 18];
        result.chan <= ctlPipe[3].chan;
        result.strobe <= ctlPipe[3].lastTap & ctlPipe[3].commit;   // Only accepted frames
    end

endmodule

//--- src/outputPublisher.sv
`timescale 1ns/10ps

module outputPublisher (
    input  logic           iClk,
    input  logic           iRst,
    input  firPkg::resultT result,
    output firPkg::sampleT oData0,
    output logic           oData0Changed,
    output firPkg::sampleT oData1,
    output logic           oData1Changed
);

    firPkg::sampleT [1:0] dataQ;
    logic [1:0]           loadQ;   // Channel loaded last cycle
    logic [1:0]           togQ;

    // Data first, toggle one cycle later so it marks settled data
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            dataQ <= '0;
            loadQ <= '0;
            togQ <= '0;
        end else begin
            loadQ <= '0;
            if (result.strobe) begin
                dataQ[result.chan] <= result.value;
                loadQ[result.chan] <= 1'b1;
            end
            togQ <= togQ ^ loadQ;   // Level to toggle
        end
    end

    assign oData0 = dataQ[0];
    assign oData1 = dataQ[1];
    assign oData0Changed = togQ[0];
    assign oData1Changed = togQ[1];

    // Each flip traces back to that channel's result strobe
    for (genvar c = 0; c < 2; c++) begin : gTogChk
        assert property (@(posedge iClk) disable iff (iRst)
            $changed(togQ[c]) |-> $past(result.strobe && (result.chan == c), 2));
    end

endmodule

//--- src/sampleCapture.sv
`timescale 1ns/10ps

module sampleCapture (
    input  logic              iClk,
    input  logic              iRst,
    input  logic              iData0Changed,
    input  firPkg::sampleT    iData0,
    input  logic              iData1Changed,
    input  firPkg::sampleT    iData1,
    input  firPkg::slotEntryT slotPs1,
    output firPkg::sampleT    pendingData,   // Scheduled channel's sample, ps2
    output logic              pendingNew     // Sample not taken before
);

    firPkg::sampleT [1:0] inData;
    firPkg::sampleT [1:0] dataQ;     // Last latched sample per channel
    logic [1:0]           inTog;
    logic [1:0]           togQ;      // Last registered input toggle
    logic [1:0]           freshQ;    // Latched sample still waiting for its slot
    logic                 takeSlot;
    logic                 takeChan;

    assign inData = {iData1, iData0};
    assign inTog = {iData1Changed, iData0Changed};
    assign takeSlot = slotPs1.doUpdate && (slotPs1.chanSel != firPkg::ChanNone);
    assign takeChan = slotPs1.chanSel[0];

    //////////////////////////////////////////////////
    // Toggle tracking
    //////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            togQ <= '0;
            freshQ <= '0;
            pendingNew <= 1'b0;
        end else begin
            pendingNew <= 1'b0;
            if (takeSlot) begin
                pendingNew <= freshQ[takeChan];
                freshQ[takeChan] <= 1'b0;
            end
            // A new arrival wins over a take in the same cycle
            for (int c = 0; c < 2; c++) begin
                if (inTog[c] != togQ[c]) begin
                    togQ[c] <= inTog[c];
                    freshQ[c] <= 1'b1;   // A second toggle just overwrites the sample
                end
            end
        end
    end

    // Sample payload
    always_ff @(posedge iClk) begin
        for (int c = 0; c < 2; c++) begin
            if (inTog[c] != togQ[c])
                dataQ[c] <= inData[c];
        end
        if (takeSlot)
            pendingData <= dataQ[takeChan];   // Held until the next update slot
    end

endmodule

//--- src/sliceSequencer.sv
`timescale 1ns/10ps

module sliceSequencer #(
    parameter int LogTimeSlices = 5
) (
    input  logic              iClk,
    input  logic              iRst,
    output firPkg::slotEntryT slotPs1,   // Sample capture stage
    output firPkg::slotEntryT slotPs2,   // Descriptor stage
    output firPkg::slotEntryT slotPs3,
    output firPkg::slotEntryT slotPs8
);

    logic [LogTimeSlices-1:0] sliceCnt;   // Free-running frame position
    logic [1:0]               enCnt;      // Update enable after reset
    firPkg::slotEntryT        slotPs0;
    firPkg::slotEntryT [4:0]  slotDly;    // Stages ps4 to ps8

    // Table lookup, doUpdate held off while the pipeline fills
    always_comb begin
        slotPs0 = firPkg::FrameSchedule[sliceCnt];
        if (enCnt != 2'd3)
            slotPs0.doUpdate = 1'b0;
    end

    //////////////////////////////////////////////////
    // Counter and stage copies
    //////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            sliceCnt <= '0;
            enCnt <= '0;
            slotPs1 <= '0;
            slotPs2 <= '0;
            slotPs3 <= '0;
            slotDly <= '0;
        end else begin
            sliceCnt <= sliceCnt + 1'b1;   // Wraps at frame end
            if (enCnt != 2'd3)
                enCnt <= enCnt + 1'b1;
            slotPs1 <= slotPs0;
            slotPs2 <= slotPs1;
            slotPs3 <= slotPs2;
            slotDly <= {slotDly[3:0], slotPs3};
        end
    end

    assign slotPs8 = slotDly[4];

    // Capture stage sees no push in the first 4 cycles out of reset
    assert property (@(posedge iClk) disable iff (iRst)
        $fell(iRst) |-> !slotPs1.doUpdate ##1 !slotPs1.doUpdate
            ##1 !slotPs1.doUpdate ##1 !slotPs1.doUpdate);

endmodule

//--- src/tapAddressGen.sv
`timescale 1ns/10ps

module tapAddressGen #(
    parameter int LogBufferDepth = 4,
    parameter int LogNumFifos    = 1
) (
    input  logic              iClk,
    input  logic              iRst,
    input  firPkg::slotEntryT slotPs2,
    input  logic              pendingNew,
    output firPkg::tapCtlT    tapCtl       // ps4
);

    localparam int NumFifos = 1 << LogNumFifos;

    firPkg::fifoDescT          descMem [NumFifos];
    firPkg::fifoDescT          updDesc;     // Port B, update slot
    firPkg::fifoDescT          tapDescQ;    // Port A, registered for taps
    firPkg::slotEntryT         slotQ;       // ps3 copy
    logic [9:0]                updMask;
    logic [9:0]                updOffset;   // Pushed offset
    logic [9:0]                tapMask;
    logic [9:0]                tapOrigin;
    logic                      accept;
    logic                      updEnQ;
    logic [LogBufferDepth-1:0] updAddrQ;
    logic [NumFifos-1:0]       commitQ;     // Channel accepted a sample this frame

    // Smallest all-ones mask covering the length
    function automatic logic [9:0] regionMask(input logic [5:0] lenM1);
        logic [9:0] m;
        m = 10'd1;
        for (int b = 1; b < 6; b++) begin
            if (lenM1[b])
                m = (10'd2 << b) - 10'd1;
        end
        return m;
    endfunction

    initial begin
        for (int f = 0; f < NumFifos; f++)
            descMem[f] = firPkg::InitFifoDesc[f];
    end

    //////////////////////////////////////////////////
    // Update side, ps2
    //////////////////////////////////////////////////
    always_comb begin
        updDesc = descMem[slotPs2.fifoNum];
        updMask = regionMask(updDesc.lenM1);
        updOffset = (updDesc.offset & ~updMask) | ((updDesc.offset + 10'd1) & updMask);
        accept = slotPs2.doUpdate & pendingNew;
    end

    // Write-back lands before the first tap reads
    always @(posedge iClk) begin
        if (accept)
            descMem[slotPs2.fifoNum] <= '{offset: updOffset, lenM1: updDesc.lenM1};
        tapDescQ <= descMem[slotPs2.fifoNum];
        updAddrQ <= updOffset[LogBufferDepth-1:0];
    end

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            slotQ <= '0;
            updEnQ <= 1'b0;
            commitQ <= '0;
        end else begin
            slotQ <= slotPs2;
            updEnQ <= accept;
            if (slotPs2.doUpdate)
                commitQ[slotPs2.fifoNum] <= accept;   // Kept until lastTap
        end
    end

    //////////////////////////////////////////////////
    // Tap addresses, ps3 to ps4
    //////////////////////////////////////////////////
    assign tapMask = regionMask(tapDescQ.lenM1);
    assign tapOrigin = tapDescQ.offset & ~tapMask;

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            tapCtl <= '0;
        end else begin
            tapCtl.wrEn <= updEnQ;
            tapCtl.wrAddr <= updAddrQ;
            tapCtl.macOp <= slotQ.macOp;
            tapCtl.lastTap <= slotQ.lastTap;
            tapCtl.commit <= slotQ.lastTap & commitQ[slotQ.fifoNum];
            tapCtl.chan <= slotQ.fifoNum;
            tapCtl.spare <= '0;
            if (slotQ.firstTap) begin
                tapCtl.histAddr <= tapDescQ.offset[LogBufferDepth-1:0];   // Newest sample
                tapCtl.coefAddr <= tapOrigin[LogBufferDepth-1:0];
            end else begin
                // History walks back, wrapping in the region
                tapCtl.histAddr <= tapOrigin[LogBufferDepth-1:0]
                    | ((tapCtl.histAddr - 1'b1) & tapMask[LogBufferDepth-1:0]);
                tapCtl.coefAddr <= tapCtl.coefAddr + 1'b1;
            end
        end
    end

    // A new sum must start on every first tap
    assert property (@(posedge iClk) disable iff (iRst)
        slotQ.firstTap |=> (tapCtl.macOp == firPkg::macMul));

endmodule
